// File: design/picoio_config.svh
/*
 * port address map, out-of-bounds marker, validity flag codes
 * and the transmit strobe hold length
 */
`ifndef PICOIO_CONFIG_SVH
`define PICOIO_CONFIG_SVH

////////////////////////////// base ports
`define PA_PBTNS        8'h00 // in: pushbuttons
`define PA_SLSWTCH      8'h01 // in: switches 7:0
`define PA_LEDS         8'h02 // out: leds 7:0
`define PA_DIG3         8'h03
`define PA_DIG2         8'h04
`define PA_DIG1         8'h05
`define PA_DIG0         8'h06
`define PA_DP           8'h07 // out: decimal points 3:0
`define PA_OOB          8'h08 // out: out-of-bounds byte

////////////////////////////// board interface
`define PA_CONN_EST     8'h09 // in: link status bits 7:6
`define PA_CURSOR_CHECK 8'h0A // out: cursor and read address
`define PA_RAM_W_ADDR   8'h0B // out: write address, sets write enable
`define PA_VALID_FLAG   8'h0C // in: placement check result

////////////////////////////// extended ports
`define PA_SLSWTCH1508  8'h11 // in: switches 15:8
`define PA_LEDS1508     8'h12 // out: leds 15:8
`define PA_RAM_SELECT   8'h13 // out: us/them bank
`define PA_DIG6         8'h14
`define PA_DIG5         8'h15
`define PA_DIG4         8'h16
`define PA_DP0704       8'h17 // out: decimal points 7:4
`define PA_RAM_W_VAL    8'h18 // out: cell value to write
`define PA_DATA_RX      8'h19 // in: byte from the other board
`define PA_DIG7         8'h1A // digit 7 sits in the old ship-check slot
`define PA_DATA_TX      8'h1E // out: byte to the other board
`define PA_DATA_RAM     8'h1F // in: selected bank read value

////////////////////////////// flag values
`define OUT_OF_BOUNDS   8'hFF
`define VALID_FLAG      8'h01
`define INVALID_FLAG    8'h00

`define TX_HOLD_CYCLES  2     // send strobe length in clocks

`endif

// File: design/picoio_pkg.sv
/*
 * shared vector types and the bank select enum
 */
package picoio_pkg;

  typedef logic [7:0]  portAddrT; // processor port id
  typedef logic [7:0]  byteT;     // generic data byte
  typedef logic [15:0] ledT;
  typedef logic [15:0] switchT;
  typedef logic [4:0]  buttonT;
  typedef logic [4:0]  digitT;    // seven segment digit code
  typedef logic [3:0]  dpNibbleT; // four decimal points
  typedef logic [1:0]  cellT;     // board cell from ram

  // which board ram the processor talks to
  typedef enum logic {
    US   = 1'b0, // our ships
    THEM = 1'b1  // our guesses
  } ramSelT;

endpackage

// File: design/displayRegs.sv
/*
 * led bank, eight digit registers and decimal point nibbles
 */
`timescale 1ns/1ps
`include "picoio_config.svh"

module displayRegs (
  input  logic                clk,
  input  logic                rst,
  input  picoio_pkg::portAddrT portId,
  input  picoio_pkg::byteT    outPort,
  input  logic                writeStrobe,
  output picoio_pkg::ledT     leds,
  output picoio_pkg::digitT   dig0,
  output picoio_pkg::digitT   dig1,
  output picoio_pkg::digitT   dig2,
  output picoio_pkg::digitT   dig3,
  output picoio_pkg::digitT   dig4,
  output picoio_pkg::digitT   dig5,
  output picoio_pkg::digitT   dig6,
  output picoio_pkg::digitT   dig7,
  output picoio_pkg::dpNibbleT dpLower,
  output picoio_pkg::dpNibbleT dpUpper
);

  always_ff @(posedge clk) begin
    if (rst) begin
      leds    <= '0;
      dig0    <= '0;
      dig1    <= '0;
      dig2    <= '0;
      dig3    <= '0;
      dig4    <= '0;
      dig5    <= '0;
      dig6    <= '0;
      dig7    <= '0;
      dpLower <= '0;
      dpUpper <= '0;
    end else if (writeStrobe) begin
      case (portId)
        `PA_LEDS:      leds[7:0]  <= outPort;      // low byte
        `PA_LEDS1508:  leds[15:8] <= outPort;      // high byte
        `PA_DIG0:      dig0 <= outPort[4:0];
        `PA_DIG1:      dig1 <= outPort[4:0];
        `PA_DIG2:      dig2 <= outPort[4:0];
        `PA_DIG3:      dig3 <= outPort[4:0];
        `PA_DIG4:      dig4 <= outPort[4:0];
        `PA_DIG5:      dig5 <= outPort[4:0];
        `PA_DIG6:      dig6 <= outPort[4:0];
        `PA_DIG7:      dig7 <= outPort[4:0];       // moved off 0x13
        `PA_DP:        dpLower <= outPort[3:0];    // points 3:0
        `PA_DP0704:    dpUpper <= outPort[3:0];    // points 7:4
        default: ;                                 // not a display port
      endcase
    end
  end

endmodule

// File: design/boardRamPort.sv
/*
 * us/them board ram access registers with bank routing,
 * write enable handling and the latched cursor
 */
`timescale 1ns/1ps
`include "picoio_config.svh"

module boardRamPort (
  input  logic                 clk,
  input  logic                 rst,
  input  picoio_pkg::portAddrT portId,
  input  picoio_pkg::byteT     outPort,
  input  logic                 writeStrobe,
  output picoio_pkg::ramSelT   ramSel,
  output picoio_pkg::byteT     cursor,
  output picoio_pkg::byteT     usReadAddr,
  output picoio_pkg::byteT     usWriteAddr,
  output logic                 usWriteEn,
  output picoio_pkg::cellT     usWriteValue,
  output picoio_pkg::byteT     themReadAddr,
  output picoio_pkg::byteT     themWriteAddr,
  output logic                 themWriteEn,
  output picoio_pkg::cellT     themWriteValue
);

  logic selUs; // current bank is ours

  assign selUs = (ramSel == picoio_pkg::US);

  always_ff @(posedge clk) begin
    if (rst) begin
      ramSel         <= picoio_pkg::US;
      cursor         <= '0;
      usReadAddr     <= '0;
      usWriteAddr    <= '0;
      usWriteEn      <= 1'b0;
      usWriteValue   <= '0;
      themReadAddr   <= '0;
      themWriteAddr  <= '0;
      themWriteEn    <= 1'b0;
      themWriteValue <= '0;
    end else if (writeStrobe) begin
      case (portId)
        `PA_RAM_SELECT: ramSel <= picoio_pkg::ramSelT'(outPort[0]);

        ////////////////////////////// read request
        `PA_CURSOR_CHECK: begin
          cursor      <= outPort;
          usWriteEn   <= 1'b0;           // both banks back to read
          themWriteEn <= 1'b0;
          if (selUs) usReadAddr   <= outPort;
          else       themReadAddr <= outPort;
        end

        ////////////////////////////// write request
        `PA_RAM_W_ADDR: begin
          if (selUs) begin
            usWriteAddr <= outPort;
            usWriteEn   <= 1'b1;         // held until next cursor check
          end else begin
            themWriteAddr <= outPort;
            themWriteEn   <= 1'b1;
          end
        end

        `PA_RAM_W_VAL: begin
          if (selUs) usWriteValue   <= outPort[1:0];
          else       themWriteValue <= outPort[1:0];
        end

        default: ;
      endcase
    end
  end

endmodule

// File: design/placementCheck.sv
/*
 * out-of-bounds register, saturating occupancy accumulator
 * and the combinational placement validity flag
 */
`timescale 1ns/1ps
`include "picoio_config.svh"

module placementCheck (
  input  logic                 clk,
  input  logic                 rst,
  input  picoio_pkg::portAddrT portId,
  input  picoio_pkg::byteT     outPort,
  input  logic                 writeStrobe,
  input  picoio_pkg::cellT     usReadValue,
  output picoio_pkg::byteT     validFlag,
  output picoio_pkg::byteT     oobByte
);

  picoio_pkg::byteT occAcc; // sum of occupied cells since last flag read
  logic [8:0]       occSum; // one extra bit to catch overflow

  assign occSum = {1'b0, occAcc} + {7'b0, usReadValue};

  always_ff @(posedge clk) begin
    if (rst) begin
      oobByte <= '0;
      occAcc  <= '0;
    end else begin
      if (writeStrobe && portId == `PA_OOB) oobByte <= outPort;
      // flag read restarts the sum, any other cycle adds
      if (portId == `PA_VALID_FLAG) occAcc <= '0;
      else                          occAcc <= occSum[8] ? 8'hFF : occSum[7:0];
    end
  end

  // free and in bounds only when nothing was hit
  assign validFlag = (oobByte != `OUT_OF_BOUNDS && occAcc == '0) ?
                     `VALID_FLAG : `INVALID_FLAG;

endmodule

// File: design/linkTransmitter.sv
/*
 * transmit data register and stretched send strobe
 */
`timescale 1ns/1ps
`include "picoio_config.svh"

module linkTransmitter (
  input  logic                 clk,
  input  logic                 rst,
  input  picoio_pkg::portAddrT portId,
  input  picoio_pkg::byteT     outPort,
  input  logic                 writeStrobe,
  output picoio_pkg::byteT     txData,
  output logic                 txSend
);

  localparam int HoldW = $clog2(`TX_HOLD_CYCLES + 1);

  logic [HoldW-1:0] holdCnt; // cycles of strobe left

  always_ff @(posedge clk) begin
    if (rst) begin
      txData  <= '0;
      holdCnt <= '0;
    end else if (writeStrobe && portId == `PA_DATA_TX) begin
      txData  <= outPort;
      holdCnt <= HoldW'(`TX_HOLD_CYCLES); // restart on every write
    end else if (holdCnt != '0) begin
      holdCnt <= holdCnt - 1'b1;
    end
  end

  assign txSend = (holdCnt != '0);

endmodule

// File: design/hostPort.sv
/*
 * registered read-back mux over the port map
 * and the closed-loop interrupt latch
 */
`timescale 1ns/1ps
`include "picoio_config.svh"

module hostPort (
  input  logic                  clk,
  input  logic                  rst,
  input  picoio_pkg::portAddrT  portId,
  // board side
  input  picoio_pkg::buttonT    dbBtns,
  input  picoio_pkg::switchT    dbSw,
  input  logic                  connEstablished,
  input  logic                  rxDataReady,
  input  picoio_pkg::byteT      rxData,
  input  picoio_pkg::cellT      usReadValue,
  input  picoio_pkg::cellT      themReadValue,
  // register read-back
  input  picoio_pkg::ledT       leds,
  input  picoio_pkg::digitT     dig0,
  input  picoio_pkg::digitT     dig1,
  input  picoio_pkg::digitT     dig2,
  input  picoio_pkg::digitT     dig3,
  input  picoio_pkg::digitT     dig4,
  input  picoio_pkg::digitT     dig5,
  input  picoio_pkg::digitT     dig6,
  input  picoio_pkg::digitT     dig7,
  input  picoio_pkg::dpNibbleT  dpLower,
  input  picoio_pkg::dpNibbleT  dpUpper,
  input  picoio_pkg::ramSelT    ramSel,
  input  picoio_pkg::byteT      usReadAddr,
  input  picoio_pkg::byteT      usWriteAddr,
  input  picoio_pkg::cellT      usWriteValue,
  input  picoio_pkg::byteT      themReadAddr,
  input  picoio_pkg::byteT      themWriteAddr,
  input  picoio_pkg::cellT      themWriteValue,
  input  picoio_pkg::byteT      validFlag,
  input  picoio_pkg::byteT      oobByte,
  input  picoio_pkg::byteT      txData,
  // interrupt handshake
  input  logic                  intRequest,
  input  logic                  interruptAck,
  output picoio_pkg::byteT      inPort,
  output logic                  interrupt
);

  logic selUs;

  assign selUs = (ramSel == picoio_pkg::US);

  ////////////////////////////// read mux
  always_ff @(posedge clk) begin
    if (rst) begin
      inPort <= '0;
    end else begin
      case (portId)
        `PA_PBTNS:        inPort <= {3'b000, dbBtns};
        `PA_SLSWTCH:      inPort <= dbSw[7:0];
        `PA_SLSWTCH1508:  inPort <= dbSw[15:8];
        `PA_LEDS:         inPort <= leds[7:0];
        `PA_LEDS1508:     inPort <= leds[15:8];
        `PA_DIG0:         inPort <= {3'b000, dig0};
        `PA_DIG1:         inPort <= {3'b000, dig1};
        `PA_DIG2:         inPort <= {3'b000, dig2};
        `PA_DIG3:         inPort <= {3'b000, dig3};
        `PA_DIG4:         inPort <= {3'b000, dig4};
        `PA_DIG5:         inPort <= {3'b000, dig5};
        `PA_DIG6:         inPort <= {3'b000, dig6};
        `PA_DIG7:         inPort <= {3'b000, dig7};
        `PA_DP:           inPort <= {4'b0000, dpLower};
        `PA_DP0704:       inPort <= {4'b0000, dpUpper};
        `PA_OOB:          inPort <= oobByte;
        `PA_CONN_EST:     inPort <= {connEstablished, rxDataReady, 6'b000000}; // status in msbs
        `PA_CURSOR_CHECK: inPort <= selUs ? usReadAddr : themReadAddr;
        `PA_RAM_W_ADDR:   inPort <= selUs ? usWriteAddr : themWriteAddr;
        `PA_VALID_FLAG:   inPort <= validFlag;     // accumulator clears on this edge
        `PA_RAM_SELECT:   inPort <= {7'b0000000, ramSel};
        `PA_RAM_W_VAL:    inPort <= {6'b000000, selUs ? usWriteValue : themWriteValue};
        `PA_DATA_RX:      inPort <= rxData;
        `PA_DATA_TX:      inPort <= txData;
        `PA_DATA_RAM:     inPort <= {6'b000000, selUs ? usReadValue : themReadValue};
        default:          inPort <= 8'h00;         // unmapped
      endcase
    end
  end

  ////////////////////////////// interrupt latch
  always_ff @(posedge clk) begin
    if (rst)               interrupt <= 1'b0;
    else if (interruptAck) interrupt <= 1'b0; // ack wins over a new request
    else if (intRequest)   interrupt <= 1'b1;
  end

endmodule

// File: design/picoIoTop.sv
/*
 * picoblaze i/o block top: display, board ram port,
 * placement check, link transmitter and host read port
 */
`timescale 1ns/1ps

module picoIoTop (
  input  logic                  clk,
  input  logic                  rst,
  input  picoio_pkg::portAddrT  portId,
  input  picoio_pkg::byteT      outPort,
  input  logic                  writeStrobe,
  output picoio_pkg::byteT      inPort,
  input  logic                  intRequest,
  input  logic                  interruptAck,
  output logic                  interrupt,
  input  picoio_pkg::buttonT    dbBtns,
  input  picoio_pkg::switchT    dbSw,
  output picoio_pkg::ledT       leds,
  output picoio_pkg::digitT     dig0, dig1, dig2, dig3,
  output picoio_pkg::digitT     dig4, dig5, dig6, dig7,
  output picoio_pkg::dpNibbleT  dpLower, dpUpper,
  output picoio_pkg::ramSelT    ramSel,
  output picoio_pkg::byteT      cursor,
  output picoio_pkg::byteT      usReadAddr, usWriteAddr,
  output logic                  usWriteEn,
  output picoio_pkg::cellT      usWriteValue,
  input  picoio_pkg::cellT      usReadValue,
  output picoio_pkg::byteT      themReadAddr, themWriteAddr,
  output logic                  themWriteEn,
  output picoio_pkg::cellT      themWriteValue,
  input  picoio_pkg::cellT      themReadValue,
  input  logic                  connEstablished,
  input  logic                  rxDataReady,
  input  picoio_pkg::byteT      rxData,
  output picoio_pkg::byteT      txData,
  output logic                  txSend
);

  picoio_pkg::byteT validFlag; // placement result to read mux
  picoio_pkg::byteT oobByte;

  displayRegs uDisplay (.clk, .rst, .portId, .outPort, .writeStrobe, .leds,
    .dig0, .dig1, .dig2, .dig3, .dig4, .dig5, .dig6, .dig7, .dpLower, .dpUpper);

  boardRamPort uRam (.clk, .rst, .portId, .outPort, .writeStrobe, .ramSel, .cursor,
    .usReadAddr, .usWriteAddr, .usWriteEn, .usWriteValue,
    .themReadAddr, .themWriteAddr, .themWriteEn, .themWriteValue);

  placementCheck uPlace (.clk, .rst, .portId, .outPort, .writeStrobe, .usReadValue,
    .validFlag, .oobByte);

  linkTransmitter uLink (.clk, .rst, .portId, .outPort, .writeStrobe, .txData, .txSend);

  hostPort uHost (.clk, .rst, .portId, .dbBtns, .dbSw, .connEstablished, .rxDataReady,
    .rxData, .usReadValue, .themReadValue, .leds,
    .dig0, .dig1, .dig2, .dig3, .dig4, .dig5, .dig6, .dig7, .dpLower, .dpUpper,
    .ramSel, .usReadAddr, .usWriteAddr, .usWriteValue,
    .themReadAddr, .themWriteAddr, .themWriteValue,
    .validFlag, .oobByte, .txData, .intRequest, .interruptAck, .inPort, .interrupt);

endmodule

// File: tb/picoIo_props.sv
/*
 * send strobe, write enable and interrupt rules, bound into picoIoTop
 */
`timescale 1ns/1ps
`include "picoio_config.svh"

module picoIoProps (
  input logic                 clk,
  input logic                 rst,
  input picoio_pkg::portAddrT portId,
  input logic                 writeStrobe,
  input logic                 txSend,
  input logic                 usWriteEn,
  input logic                 themWriteEn,
  input logic                 interrupt,
  input logic                 interruptAck
);

  logic txWrite; // write to the transmit port
  int   failCount = 0; // rule violations seen so far

  assign txWrite = writeStrobe && (portId == `PA_DATA_TX);

  // strobe gone once the hold window after the last write has passed
  txSendBounded: assert property (@(posedge clk) disable iff (rst)
    txWrite ##1 (!txWrite) [*`TX_HOLD_CYCLES] |=> !txSend)
    else begin
      $error("txSend stayed high past its hold window");
      failCount++;
    end

  enablesApart: assert property (@(posedge clk) disable iff (rst)
    !($rose(usWriteEn) && $rose(themWriteEn)))   // one bank per write address
    else begin
      $error("both write enables rose on one edge");
      failCount++;
    end

  intFallsOnAck: assert property (@(posedge clk) disable iff (rst)
    $fell(interrupt) |-> $past(interruptAck) || $past(rst))
    else begin
      $error("interrupt dropped without an acknowledge");
      failCount++;
    end

endmodule

bind picoIoTop picoIoProps uProps (.clk, .rst, .portId, .writeStrobe, .txSend,
  .usWriteEn, .themWriteEn, .interrupt, .interruptAck);

// File: tb/picoIoTb.sv
/*
 * testbench for picoIoTop: lfsr stimulus, register map model,
 * per-cycle output compare, per-test report and timeout
 */
`timescale 1ns/1ps
`include "picoio_config.svh"

module picoIoTb;

  localparam int MaxCycles = 2000;                   // tests need roughly 650 cycles
  localparam picoio_pkg::portAddrT IdleAddr = 8'h1B; // unmapped, reads zero

  logic                  clk;
  logic                  rst;
  picoio_pkg::portAddrT  portId;
  picoio_pkg::byteT      outPort;
  logic                  writeStrobe;
  picoio_pkg::byteT      inPort;
  logic                  intRequest, interruptAck, interrupt;
  picoio_pkg::buttonT    dbBtns;
  picoio_pkg::switchT    dbSw;
  picoio_pkg::ledT       leds;
  picoio_pkg::digitT     digOut [8];
  picoio_pkg::dpNibbleT  dpLower, dpUpper;
  picoio_pkg::ramSelT    ramSel;
  picoio_pkg::byteT      cursor, usReadAddr, usWriteAddr, themReadAddr, themWriteAddr;
  logic                  usWriteEn, themWriteEn;
  picoio_pkg::cellT      usWriteValue, themWriteValue, usReadValue, themReadValue;
  logic                  connEstablished, rxDataReady, txSend;
  picoio_pkg::byteT      rxData, txData;

  ////////////////////////////// model state
  picoio_pkg::ledT       mLeds;
  picoio_pkg::digitT     mDig [8];
  picoio_pkg::dpNibbleT  mDpLo, mDpHi;
  logic                  mSel;                  // 1 = them bank
  picoio_pkg::byteT      mCursor, mUsRa, mUsWa, mThRa, mThWa, mOob, mTx, mIn;
  picoio_pkg::cellT      mUsWv, mThWv;
  logic                  mUsWe, mThWe, mInt;
  int                    mAcc, mHold;           // occupancy sum, strobe cycles left

  logic [31:0] lfsr = 32'h6344_eaf3;
  picoio_pkg::cellT cellMask, cellOr;           // shape usReadValue per test
  logic checkOn = 1'b0;
  int   errCount = 0, testStartErr = 0, testsRun = 0, testsFailed = 0, cycleCount = 0;

  picoIoTop UUT (
    .clk, .rst, .portId, .outPort, .writeStrobe, .inPort, .intRequest, .interruptAck,
    .interrupt, .dbBtns, .dbSw, .leds,
    .dig0(digOut[0]), .dig1(digOut[1]), .dig2(digOut[2]), .dig3(digOut[3]),
    .dig4(digOut[4]), .dig5(digOut[5]), .dig6(digOut[6]), .dig7(digOut[7]),
    .dpLower, .dpUpper, .ramSel, .cursor, .usReadAddr, .usWriteAddr, .usWriteEn,
    .usWriteValue, .usReadValue, .themReadAddr, .themWriteAddr, .themWriteEn,
    .themWriteValue, .themReadValue, .connEstablished, .rxDataReady, .rxData,
    .txData, .txSend);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      r = {r[30:0], lfsr[0]};      // one step per bit
    end
    return r;
  endfunction

  function automatic picoio_pkg::portAddrT digAddr(input int i);
    case (i)
      0: return `PA_DIG0;
      1: return `PA_DIG1;
      2: return `PA_DIG2;
      3: return `PA_DIG3;
      4: return `PA_DIG4;
      5: return `PA_DIG5;
      6: return `PA_DIG6;
      default: return `PA_DIG7;
    endcase
  endfunction

  // 0..7 digits, then led bytes and dp nibbles
  function automatic picoio_pkg::portAddrT dispAddr(input int k);
    case (k)
      8: return `PA_LEDS;
      9: return `PA_LEDS1508;
      10: return `PA_DP;
      11: return `PA_DP0704;
      default: return digAddr(k);
    endcase
  endfunction

  ////////////////////////////// reference model
  function automatic picoio_pkg::byteT modelRead(input picoio_pkg::portAddrT a);
    picoio_pkg::byteT r;
    int i;
    r = 8'h00;                                  // unmapped default
    for (i = 0; i < 8; i++) if (a == digAddr(i)) r = {3'b000, mDig[i]};
    case (a)
      `PA_PBTNS:        r = {3'b000, dbBtns};
      `PA_SLSWTCH:      r = dbSw[7:0];
      `PA_SLSWTCH1508:  r = dbSw[15:8];
      `PA_LEDS:         r = mLeds[7:0];
      `PA_LEDS1508:     r = mLeds[15:8];
      `PA_DP:           r = {4'h0, mDpLo};
      `PA_DP0704:       r = {4'h0, mDpHi};
      `PA_OOB:          r = mOob;
      `PA_CONN_EST:     r = {connEstablished, rxDataReady, 6'b000000};
      `PA_CURSOR_CHECK: r = mSel ? mThRa : mUsRa;
      `PA_RAM_W_ADDR:   r = mSel ? mThWa : mUsWa;
      `PA_VALID_FLAG:   r = (mOob != `OUT_OF_BOUNDS && mAcc == 0) ? `VALID_FLAG : `INVALID_FLAG;
      `PA_RAM_SELECT:   r = {7'b0000000, mSel};
      `PA_RAM_W_VAL:    r = {6'b000000, mSel ? mThWv : mUsWv};
      `PA_DATA_RX:      r = rxData;
      `PA_DATA_TX:      r = mTx;
      `PA_DATA_RAM:     r = {6'b000000, mSel ? themReadValue : usReadValue};
      default: ;
    endcase
    return r;
  endfunction

  function automatic void modelReset();
    int i;
    for (i = 0; i < 8; i++) mDig[i] = '0;
    mLeds   = '0;
    mDpLo   = '0;
    mDpHi   = '0;
    mSel    = 1'b0;                             // us bank
    mCursor = '0;
    mUsRa   = '0;
    mUsWa   = '0;
    mThRa   = '0;
    mThWa   = '0;
    mOob    = '0;
    mTx     = '0;
    mIn     = '0;
    mUsWv   = '0;
    mThWv   = '0;
    mUsWe   = 1'b0;
    mThWe   = 1'b0;
    mInt    = 1'b0;
    mAcc    = 0;
    mHold   = 0;
  endfunction

  // one clock edge of the whole port block
  function automatic void modelStep();
    picoio_pkg::byteT d;
    int i;
    d = outPort;
    mIn = modelRead(portId);                    // read sees state before this edge
    if (interruptAck) mInt = 1'b0;
    else if (intRequest) mInt = 1'b1;
    if (portId == `PA_VALID_FLAG) mAcc = 0;
    else mAcc = (mAcc + usReadValue > 255) ? 255 : mAcc + usReadValue;
    if (mHold > 0) mHold--;
    if (writeStrobe) begin
      for (i = 0; i < 8; i++) if (portId == digAddr(i)) mDig[i] = d[4:0];
      case (portId)
        `PA_LEDS:       mLeds[7:0] = d;
        `PA_LEDS1508:   mLeds[15:8] = d;
        `PA_DP:         mDpLo = d[3:0];
        `PA_DP0704:     mDpHi = d[3:0];
        `PA_OOB:        mOob = d;
        `PA_RAM_SELECT: mSel = d[0];
        `PA_CURSOR_CHECK: begin
          mCursor = d;
          mUsWe   = 1'b0;
          mThWe   = 1'b0;
          if (mSel) mThRa = d;
          else mUsRa = d;
        end
        `PA_RAM_W_ADDR: begin
          if (mSel) begin
            mThWa = d;
            mThWe = 1'b1;
          end else begin
            mUsWa = d;
            mUsWe = 1'b1;
          end
        end
        `PA_RAM_W_VAL: begin
          if (mSel) mThWv = d[1:0];
          else mUsWv = d[1:0];
        end
        `PA_DATA_TX: begin
          mTx   = d;
          mHold = `TX_HOLD_CYCLES;              // restart on every write
        end
        default: ;
      endcase
    end
  endfunction

  always @(posedge clk) begin
    if (rst) modelReset();
    else modelStep();
  end

  ////////////////////////////// checking
  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic compareAll();
    int i;
    checkVal("inPort", 32'(inPort), 32'(mIn));
    checkVal("interrupt", 32'(interrupt), 32'(mInt));
    checkVal("leds", 32'(leds), 32'(mLeds));
    for (i = 0; i < 8; i++) checkVal($sformatf("dig%0d", i), 32'(digOut[i]), 32'(mDig[i]));
    checkVal("dpLower", 32'(dpLower), 32'(mDpLo));
    checkVal("dpUpper", 32'(dpUpper), 32'(mDpHi));
    checkVal("ramSel", 32'(ramSel), 32'(mSel));
    checkVal("cursor", 32'(cursor), 32'(mCursor));
    checkVal("usReadAddr", 32'(usReadAddr), 32'(mUsRa));
    checkVal("usWriteAddr", 32'(usWriteAddr), 32'(mUsWa));
    checkVal("usWriteEn", 32'(usWriteEn), 32'(mUsWe));
    checkVal("usWriteValue", 32'(usWriteValue), 32'(mUsWv));
    checkVal("themReadAddr", 32'(themReadAddr), 32'(mThRa));
    checkVal("themWriteAddr", 32'(themWriteAddr), 32'(mThWa));
    checkVal("themWriteEn", 32'(themWriteEn), 32'(mThWe));
    checkVal("themWriteValue", 32'(themWriteValue), 32'(mThWv));
    checkVal("txData", 32'(txData), 32'(mTx));
    checkVal("txSend", 32'(txSend), 32'(mHold != 0));
  endtask

  always @(negedge clk) begin                   // outputs settled since the rising edge
    if (checkOn) compareAll();
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= MaxCycles) begin
      $display("timeout: run did not finish within %0d cycles", MaxCycles);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////////////// stimulus
  // called on a falling edge, returns on the next one
  task automatic busCycle(input picoio_pkg::portAddrT a, input picoio_pkg::byteT d,
                          input logic we);
    portId        = a;
    outPort       = d;
    writeStrobe   = we;
    usReadValue   = (2'(randBits(2)) & cellMask) | cellOr;
    themReadValue = 2'(randBits(2));
    dbBtns        = 5'(randBits(5));
    dbSw          = 16'(randBits(16));
    @(negedge clk);
  endtask

  task automatic reportTest(input string name);
    testsRun++;
    if (errCount != testStartErr) testsFailed++;
    $display("test %0d %-22s %s (%0d errors)", testsRun, name,
             (errCount == testStartErr) ? "passed" : "failed", errCount - testStartErr);
    testStartErr = errCount;
  endtask

  initial begin
    picoio_pkg::portAddrT a;
    picoio_pkg::byteT     oob;
    int b;
    int cnt;
    portId = '0;
    outPort = '0;
    writeStrobe = 1'b0;
    intRequest = 1'b0;
    interruptAck = 1'b0;
    dbBtns = '0;
    dbSw = '0;
    usReadValue = '0;
    themReadValue = '0;
    connEstablished = 1'b0;
    rxDataReady = 1'b0;
    rxData = '0;
    cellMask = 2'b11;
    cellOr = 2'b00;
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    checkOn = 1'b1;

    busCycle(IdleAddr, 8'h00, 1'b0);            // 1: reset state
    checkVal("ramSel", 32'(ramSel), 32'(picoio_pkg::US));
    reportTest("reset values");

    repeat (60) begin                           // 2: write then read back
      a = dispAddr(int'(randBits(4) % 12));
      busCycle(a, 8'(randBits(8)), 1'b1);
      busCycle(a, 8'(randBits(8)), 1'b0);       // strobe low must not write
    end
    reportTest("display registers");

    for (b = 0; b < 2; b++) begin               // 3: us bank, then them
      busCycle(`PA_RAM_SELECT, {7'(randBits(7)), b[0]}, 1'b1);
      repeat (12) begin
        busCycle(`PA_CURSOR_CHECK, 8'(randBits(8)), 1'b1);
        busCycle(`PA_RAM_W_ADDR, 8'(randBits(8)), 1'b1);
        busCycle(`PA_RAM_W_VAL, 8'(randBits(8)), 1'b1);
        busCycle(`PA_DATA_RAM, 8'h00, 1'b0);
        busCycle(`PA_CURSOR_CHECK, 8'h00, 1'b0);
        busCycle(`PA_RAM_W_ADDR, 8'h00, 1'b0);
        busCycle(`PA_RAM_W_VAL, 8'h00, 1'b0);
        busCycle(`PA_RAM_SELECT, 8'h00, 1'b0);
      end
    end
    reportTest("bank routing");

    repeat (8) begin                            // 4: placement check
      oob = randBits(1) ? `OUT_OF_BOUNDS : 8'(randBits(8));
      busCycle(`PA_OOB, oob, 1'b1);
      cellMask = randBits(1) ? 2'b11 : 2'b00;   // free or hit cells
      repeat (10) busCycle(IdleAddr, 8'h00, 1'b0);
      busCycle(`PA_VALID_FLAG, 8'h00, 1'b0);
      busCycle(`PA_VALID_FLAG, 8'h00, 1'b0);
      checkVal("inPort second flag read", 32'(inPort),
               (oob == `OUT_OF_BOUNDS) ? 32'(`INVALID_FLAG) : 32'(`VALID_FLAG));
    end
    cellMask = 2'b00;
    busCycle(`PA_OOB, 8'h10, 1'b1);
    busCycle(`PA_VALID_FLAG, 8'h00, 1'b0);
    cellOr = 2'b10;
    repeat (128) busCycle(IdleAddr, 8'h00, 1'b0); // 256 would wrap to zero
    cellOr = 2'b00;
    busCycle(`PA_VALID_FLAG, 8'h00, 1'b0);
    checkVal("inPort saturated flag", 32'(inPort), 32'(`INVALID_FLAG));
    cellMask = 2'b11;
    reportTest("placement validity");

    repeat (8) begin                            // 5: link
      if (randBits(1)) busCycle(`PA_DATA_TX, 8'(randBits(8)), 1'b1);
      busCycle(`PA_DATA_TX, 8'(randBits(8)), 1'b1);
      cnt = 0;
      repeat (4) begin
        if (txSend) cnt++;
        busCycle(`PA_DATA_TX, 8'h00, 1'b0);
      end
      checkVal("txSend cycles", 32'(cnt), 32'(`TX_HOLD_CYCLES));
      rxData = 8'(randBits(8));
      connEstablished = 1'(randBits(1));
      rxDataReady = 1'(randBits(1));
      busCycle(`PA_DATA_RX, 8'h00, 1'b0);
      busCycle(`PA_CONN_EST, 8'h00, 1'b0);
    end
    reportTest("link transmit/receive");

    repeat (6) begin                            // 6: interrupt latch
      intRequest = 1'b1;
      busCycle(IdleAddr, 8'h00, 1'b0);
      intRequest = 1'b0;
      repeat (int'(randBits(2)) + 1) busCycle(IdleAddr, 8'h00, 1'b0);
      interruptAck = 1'b1;
      intRequest = 1'(randBits(1));             // ack beats a request
      busCycle(IdleAddr, 8'h00, 1'b0);
      interruptAck = 1'b0;
      intRequest = 1'b0;
      busCycle(IdleAddr, 8'h00, 1'b0);
    end
    reportTest("interrupt latch");

    $display("summary: %0d tests, %0d failed, %0d check errors, %0d property errors",
             testsRun, testsFailed, errCount, UUT.uProps.failCount);
    if (errCount == 0 && UUT.uProps.failCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+design
design/picoio_pkg.sv
design/displayRegs.sv
design/boardRamPort.sv
design/placementCheck.sv
design/linkTransmitter.sv
design/hostPort.sv
design/picoIoTop.sv
tb/picoIo_props.sv
tb/picoIoTb.sv

// File: Bender.yml
package:
  name: picoio

sources:
  - include_dirs:
      - design
    files:
      - design/picoio_pkg.sv
      - design/displayRegs.sv
      - design/boardRamPort.sv
      - design/placementCheck.sv
      - design/linkTransmitter.sv
      - design/hostPort.sv
      - design/picoIoTop.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/picoIo_props.sv
      - tb/picoIoTb.sv
